// File: flist.f
+incdir+source
source/relm_uart_pkg.sv
source/relm_uart_core_if.sv
source/relm_uart_baud.sv
source/relm_uart_rx.sv
source/relm_uart_tx.sv
source/relm_uart_host.sv
source/relm_uart_top.sv
testbench/tb_relm_uart.sv

// File: run_sim.sh
#!/bin/sh
# build and run the UART testbench with Verilator, result taken from sim.log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_relm_uart \
	-Mdir obj_dir -o tb_relm_uart -f flist.f || { echo "build failed"; exit 1; }
./obj_dir/tb_relm_uart > sim.log 2>&1
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1
grep -q "TEST PASS" sim.log || exit 1
exit 0

// File: source/relm_uart_baud.sv
`timescale 1ns/100ps
`include "relm_uart_config.svh"

module relm_uart_baud (
	input  logic clk,
	input  logic rst_n,
	relm_uart_core_if.baud core
);
	localparam int DIV_W = $clog2(`UART_SAMPLE_DIV);
	localparam int PH_W = $clog2(`UART_OVERSAMPLE);

	logic [DIV_W-1:0] div_cnt;
	logic [PH_W-1:0] phase;
	logic sample;

	assign sample = (div_cnt == DIV_W'(`UART_SAMPLE_DIV - 1));
	assign core.sample_tick = sample;
	// last sample of a bit period.
	assign core.bit_tick = sample && (phase == PH_W'(`UART_OVERSAMPLE - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
			phase <= '0;
		end else begin
			if (sample) begin
				div_cnt <= '0;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
			if (sample) begin
				if (phase == PH_W'(`UART_OVERSAMPLE - 1)) begin
					phase <= '0;
				end else begin
					phase <= phase + 1'b1; // free running, never resynced.
				end
			end
		end
	end

endmodule

// File: source/relm_uart_config.svh
`ifndef RELM_UART_CONFIG_SVH
`define RELM_UART_CONFIG_SVH

// clocks per sample tick.
`define UART_SAMPLE_DIV 4

// samples per bit, so one bit lasts 12 clocks.
`define UART_OVERSAMPLE 3

// data bits per 8N1 frame.
`define UART_DATA_BITS 8

`endif

// File: source/relm_uart_core_if.sv
`timescale 1ns/100ps
`include "relm_uart_config.svh"

interface relm_uart_core_if;
	logic sample_tick;
	logic bit_tick; // every third sample tick.
	logic tx_load;
	logic [`UART_DATA_BITS-1:0] tx_data;
	logic tx_busy;
	logic rx_strobe;
	logic [`UART_DATA_BITS-1:0] rx_data;

	modport baud (
		output sample_tick,
		output bit_tick
	);

	modport tx_eng (
		input  sample_tick,
		input  bit_tick,
		input  tx_load,
		input  tx_data,
		output tx_busy
	);

	modport rx_eng (
		input  sample_tick,
		output rx_strobe,
		output rx_data
	);

	modport host (
		output tx_load,
		output tx_data,
		input  tx_busy,
		input  rx_strobe,
		input  rx_data
	);
endinterface

// File: source/relm_uart_host.sv
`timescale 1ns/100ps
`include "relm_uart_config.svh"

module relm_uart_host (
	input  logic clk,
	input  logic rst_n,
	input  logic cmd_valid,
	input  relm_uart_pkg::uart_cmd_t cmd_op,
	input  logic [`UART_DATA_BITS-1:0] cmd_data,
	output logic cmd_retry,
	output relm_uart_pkg::uart_status_t status,
	relm_uart_core_if.host core
);
	import relm_uart_pkg::*;

	logic take;
	logic send_take;
	logic ack_take;
	logic hold_full;
	logic [`UART_DATA_BITS-1:0] hold_data;
	logic load;
	logic rx_valid;
	logic [`UART_DATA_BITS-1:0] rx_byte;

	// only a send can be held off, and only while the holding byte waits.
	assign cmd_retry = cmd_valid && (cmd_op == cmd_send) && hold_full;
	assign take = cmd_valid && !cmd_retry;

	always_comb begin
		send_take = 1'b0;
		ack_take = 1'b0;
		case (cmd_op)
			cmd_send: send_take = take;
			cmd_ack: ack_take = take;
			default: ; // nop changes nothing.
		endcase
	end

	assign load = hold_full && !core.tx_busy;
	assign core.tx_load = load;
	assign core.tx_data = hold_data;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hold_full <= 1'b0;
			rx_valid <= 1'b0;
		end else begin
			if (send_take) begin
				hold_full <= 1'b1;
			end else if (load) begin
				hold_full <= 1'b0;
			end
			if (core.rx_strobe) begin
				rx_valid <= 1'b1; // wins over a same-cycle ack.
			end else if (ack_take) begin
				rx_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (send_take) begin
			hold_data <= cmd_data;
		end
		if (core.rx_strobe) begin
			rx_byte <= core.rx_data; // overwrites an unacked byte.
		end
	end

	assign status.tx_free = !hold_full;
	assign status.rx_valid = rx_valid;
	assign status.rx_data = rx_byte;

endmodule

// File: source/relm_uart_pkg.sv
`include "relm_uart_config.svh"

package relm_uart_pkg;

	// host command opcodes.
	typedef enum logic [1:0] {
		cmd_nop  = 2'd0,
		cmd_send = 2'd1,
		cmd_ack  = 2'd2
	} uart_cmd_t;

	// what the transmitter currently drives on the line.
	typedef enum logic [1:0] {
		tx_idle  = 2'd0,
		tx_start = 2'd1,
		tx_data  = 2'd2,
		tx_stop  = 2'd3
	} tx_state_t;

	typedef struct packed {
		logic tx_free; // holding byte empty.
		logic rx_valid;
		logic [`UART_DATA_BITS-1:0] rx_data;
	} uart_status_t;

endpackage

// File: source/relm_uart_rx.sv
`timescale 1ns/100ps
`include "relm_uart_config.svh"

module relm_uart_rx (
	input  logic clk,
	input  logic rst_n,
	input  logic rxd,
	relm_uart_core_if.rx_eng core
);
	// start bit, data bits, first stop sample and one idle sample.
	localparam int WIN = `UART_OVERSAMPLE * (`UART_DATA_BITS + 1) + 2;
	localparam int MID = `UART_OVERSAMPLE / 2;

	logic [1:0] sync;
	logic [WIN-1:0] window;
	logic capture;
	logic [`UART_DATA_BITS-1:0] centre;
	logic strobe;
	logic [`UART_DATA_BITS-1:0] data_q;

	// window[0] is the oldest sample.
	// an idle sample, then start bit, with a high stop sample arriving now.
	assign capture = core.sample_tick && window[0] && !window[1]
		&& !window[`UART_OVERSAMPLE - 1] && sync[1];

	always_comb begin
		for (int i = 0; i < `UART_DATA_BITS; i++) begin
			centre[i] = window[1 + `UART_OVERSAMPLE * (i + 1) + MID];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync <= 2'b11;
			window <= '1;
			strobe <= 1'b0;
		end else begin
			sync <= {sync[0], rxd};
			strobe <= capture;
			if (capture) begin
				window <= '1; // refill so the frame is not seen twice.
			end else if (core.sample_tick) begin
				window <= {sync[1], window[WIN-1:1]};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			data_q <= centre;
		end
	end

	assign core.rx_strobe = strobe;
	assign core.rx_data = data_q;

endmodule

// File: source/relm_uart_top.sv
`timescale 1ns/100ps
`include "relm_uart_config.svh"

module relm_uart_top (
	input  logic clk,
	input  logic rst_n,
	input  logic cmd_valid,
	input  relm_uart_pkg::uart_cmd_t cmd_op,
	input  logic [`UART_DATA_BITS-1:0] cmd_data,
	output logic cmd_retry,
	output relm_uart_pkg::uart_status_t status,
	input  logic uart_rxd,
	output logic uart_txd
);

	relm_uart_core_if core ();

	// shared sample and bit timing.
	relm_uart_baud u_baud (
		.clk   (clk),
		.rst_n (rst_n),
		.core  (core)
	);

	relm_uart_rx u_rx (
		.clk   (clk),
		.rst_n (rst_n),
		.rxd   (uart_rxd),
		.core  (core)
	);

	relm_uart_tx u_tx (
		.clk   (clk),
		.rst_n (rst_n),
		.txd   (uart_txd),
		.core  (core)
	);

	relm_uart_host u_host (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd_valid (cmd_valid),
		.cmd_op    (cmd_op),
		.cmd_data  (cmd_data),
		.cmd_retry (cmd_retry),
		.status    (status),
		.core      (core)
	);

endmodule

// File: source/relm_uart_tx.sv
`timescale 1ns/100ps
`include "relm_uart_config.svh"

module relm_uart_tx (
	input  logic clk,
	input  logic rst_n,
	output logic txd,
	relm_uart_core_if.tx_eng core
);
	import relm_uart_pkg::*;

	localparam int CNT_W = $clog2(`UART_DATA_BITS);

	tx_state_t state;
	logic [CNT_W-1:0] bit_cnt;
	logic [`UART_DATA_BITS-1:0] shift;
	logic busy;
	logic adv;

	assign adv = core.sample_tick && core.bit_tick; // one step per bit.
	assign core.tx_busy = busy;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= tx_idle;
			bit_cnt <= '0;
			txd <= 1'b1;
			busy <= 1'b0;
		end else begin
			case (state)
				tx_idle: begin
					if (core.tx_load) begin
						busy <= 1'b1;
					end else if (busy && adv) begin
						txd <= 1'b0;
						state <= tx_start;
					end
				end
				tx_start: begin
					if (adv) begin
						txd <= shift[0];
						bit_cnt <= '0;
						state <= tx_data;
					end
				end
				tx_data: begin
					if (adv) begin
						if (bit_cnt == CNT_W'(`UART_DATA_BITS - 1)) begin
							txd <= 1'b1; // stop bit.
							state <= tx_stop;
						end else begin
							txd <= shift[0];
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				tx_stop: begin
					if (adv) begin
						busy <= 1'b0;
						state <= tx_idle;
					end
				end
				default: state <= tx_idle;
			endcase
		end
	end

	// lsb first.
	always_ff @(posedge clk) begin
		if (core.tx_load) begin
			shift <= core.tx_data;
		end else if (adv && (state == tx_start || state == tx_data)) begin
			shift <= shift >> 1;
		end
	end

endmodule

// File: testbench/tb_relm_uart.sv
`timescale 1ns/100ps
`include "relm_uart_config.svh"

module tb_relm_uart;
	import relm_uart_pkg::*;

	localparam int BIT_CLKS = `UART_SAMPLE_DIV * `UART_OVERSAMPLE;
	localparam int FRAME_BITS = `UART_DATA_BITS + 2;
	localparam int CMD_TIMEOUT = 30 * BIT_CLKS;
	localparam int RX_TIMEOUT = 20 * BIT_CLKS;
	localparam int LOOP_BYTES = 4;

	logic clk;
	logic rst_n;
	logic cmd_valid;
	uart_cmd_t cmd_op;
	logic [`UART_DATA_BITS-1:0] cmd_data;
	logic cmd_retry;
	uart_status_t status;
	logic uart_rxd;
	logic uart_txd;

	logic loopback;
	logic line_drv; // line model output.
	logic quiet; // rx_valid must stay low.
	logic check_ack;
	logic [31:0] rng;
	logic [`UART_DATA_BITS-1:0] burst [3];

	relm_uart_top u_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd_valid (cmd_valid),
		.cmd_op    (cmd_op),
		.cmd_data  (cmd_data),
		.cmd_retry (cmd_retry),
		.status    (status),
		.uart_rxd  (uart_rxd),
		.uart_txd  (uart_txd)
	);

	assign uart_rxd = loopback ? uart_txd : line_drv;

	always #20 clk = ~clk;

	task automatic stop_on_error();
		$display("TEST FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_eq(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("Mismatch at %0t ns: %s expected %0h, got %0h",
				$time, name, expected, actual);
			stop_on_error();
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("Timeout at %0t ns while waiting for %s", $time, what);
		stop_on_error();
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic next_byte(output logic [`UART_DATA_BITS-1:0] b);
		rng = xorshift(rng);
		b = rng[`UART_DATA_BITS-1:0];
	endtask

	// call on a rising edge, returns on the edge that takes the command.
	task automatic issue_cmd(input uart_cmd_t op, input logic [`UART_DATA_BITS-1:0] data,
		output logic saw_retry);
		int n;
		saw_retry = 1'b0;
		n = 0;
		cmd_valid <= 1'b1;
		cmd_op <= op;
		cmd_data <= data;
		do begin
			@(negedge clk);
			if (cmd_retry) begin
				saw_retry = 1'b1;
			end
			n++;
		end while (cmd_retry && n < CMD_TIMEOUT);
		if (cmd_retry) begin
			timeout_fail("cmd_retry to drop");
		end else begin
			@(posedge clk);
			cmd_valid <= 1'b0;
			cmd_op <= cmd_nop;
		end
	endtask

	// samples uart_txd in the middle of each bit.
	task automatic check_frame(input logic [`UART_DATA_BITS-1:0] exp_byte, input int timeout);
		int n;
		logic [`UART_DATA_BITS-1:0] got;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (uart_txd && n < timeout);
		if (uart_txd) begin
			timeout_fail("a start bit on uart_txd");
		end else begin
			repeat (BIT_CLKS / 2) @(negedge clk);
			check_eq("uart_txd start bit", 0, 32'(uart_txd));
			for (int i = 0; i < `UART_DATA_BITS; i++) begin
				repeat (BIT_CLKS) @(negedge clk);
				got[i] = uart_txd;
			end
			check_eq("uart_txd data byte", 32'(exp_byte), 32'(got));
			repeat (BIT_CLKS) @(negedge clk);
			check_eq("uart_txd stop bit", 1, 32'(uart_txd));
		end
	endtask

	task automatic drive_frame(input logic [`UART_DATA_BITS-1:0] b, input logic stop);
		logic [FRAME_BITS-1:0] bits;
		bits = {stop, b, 1'b0};
		for (int i = 0; i < FRAME_BITS; i++) begin
			@(posedge clk);
			line_drv <= bits[i];
			repeat (BIT_CLKS - 1) @(posedge clk);
		end
		@(posedge clk);
		line_drv <= 1'b1; // back to idle.
	endtask

	task automatic wait_rx_valid();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!status.rx_valid && n < RX_TIMEOUT);
		if (!status.rx_valid) begin
			timeout_fail("status.rx_valid");
		end
	endtask

	retry_only_send: assert property (@(posedge clk) disable iff (!rst_n)
		cmd_retry |-> (cmd_valid && cmd_op == cmd_send))
	else begin
		$display("Mismatch at %0t ns: cmd_retry expected 0, got 1", $time);
		stop_on_error();
	end

	// bad frame and the bit periods after it.
	quiet_rx: assert property (@(posedge clk) disable iff (!rst_n)
		quiet |-> !status.rx_valid)
	else begin
		$display("Mismatch at %0t ns: status.rx_valid expected 0, got 1", $time);
		stop_on_error();
	end

	ack_drop: assert property (@(posedge clk) disable iff (!rst_n)
		(check_ack && cmd_valid && cmd_op == cmd_ack && !cmd_retry) |=> !status.rx_valid)
	else begin
		$display("Mismatch at %0t ns: status.rx_valid after cmd_ack expected 0, got 1",
			$time);
		stop_on_error();
	end

	initial begin
		logic saw_retry;
		logic [`UART_DATA_BITS-1:0] b;
		clk = 1'b0;
		rst_n = 1'b0;
		cmd_valid = 1'b0;
		cmd_op = cmd_nop;
		cmd_data = '0;
		loopback = 1'b0;
		line_drv = 1'b1;
		quiet = 1'b0;
		check_ack = 1'b0;
		rng = 32'd55;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		@(negedge clk);
		check_eq("uart_txd", 1, 32'(uart_txd));
		check_eq("cmd_retry", 0, 32'(cmd_retry));
		check_eq("status.tx_free", 1, 32'(status.tx_free));
		check_eq("status.rx_valid", 0, 32'(status.rx_valid));

		// single send.
		@(posedge clk);
		next_byte(b);
		issue_cmd(cmd_send, b, saw_retry);
		check_frame(b, 2 * BIT_CLKS);

		for (int i = 0; i < 3; i++) begin
			next_byte(burst[i]);
		end
		@(posedge clk);
		fork
			begin
				issue_cmd(cmd_send, burst[0], saw_retry);
				issue_cmd(cmd_send, burst[1], saw_retry);
				issue_cmd(cmd_send, burst[2], saw_retry);
				check_eq("cmd_retry seen by third cmd_send", 1, 32'(saw_retry));
				issue_cmd(cmd_nop, '0, saw_retry); // holding byte still full.
				check_eq("cmd_retry seen by cmd_nop", 0, 32'(saw_retry));
				issue_cmd(cmd_ack, '0, saw_retry);
				check_eq("cmd_retry seen by cmd_ack", 0, 32'(saw_retry));
			end
			begin
				for (int i = 0; i < 3; i++) begin
					check_frame(burst[i], 3 * BIT_CLKS);
				end
			end
		join

		@(posedge clk);
		loopback <= 1'b1;
		for (int i = 0; i < LOOP_BYTES; i++) begin
			next_byte(b);
			@(posedge clk);
			issue_cmd(cmd_send, b, saw_retry);
			wait_rx_valid();
			check_eq("status.rx_data", 32'(b), 32'(status.rx_data));
			@(posedge clk);
			check_ack <= 1'b1;
			issue_cmd(cmd_ack, '0, saw_retry);
			check_ack <= 1'b0;
			@(negedge clk);
			check_eq("status.rx_valid after cmd_ack", 0, 32'(status.rx_valid));
		end

		// all-zero frame with a low stop bit, never captured.
		@(posedge clk);
		loopback <= 1'b0;
		quiet <= 1'b1;
		drive_frame('0, 1'b0);
		repeat (3 * BIT_CLKS) @(posedge clk);
		quiet <= 1'b0;
		next_byte(b);
		drive_frame(b, 1'b1);
		wait_rx_valid();
		check_eq("status.rx_data", 32'(b), 32'(status.rx_data));

		@(posedge clk);
		$display("TEST PASS");
		$finish;
	end

endmodule
